// File: include/memCtrl_defs.svh
`ifndef MEMCTRL_DEFS_SVH
`define MEMCTRL_DEFS_SVH

// AXI bus widths
`define MC_ADDR_W 32
`define MC_DATA_W 32

// Transfer slots, one AXI ID each
`define MC_NUM_SLOTS 4
`define MC_ID_W 2

// Data cache geometry
`define MC_LINE_WORDS 4
`define MC_CACHE_ADDR_W 10

// Client tag for single-word accesses
`define MC_TAG_W 8

// R channel skid buffer
`define MC_RBUF_DEPTH 2

`endif

// File: hdl/memCtrlPkg.sv
`default_nettype none

`include "memCtrl_defs.svh"

package memCtrlPkg;

    typedef logic [`MC_ADDR_W-1:0] addr_t;
    typedef logic [`MC_DATA_W-1:0] word_t;
    typedef logic [`MC_ID_W-1:0] slotId_t;
    typedef logic [`MC_CACHE_ADDR_W-1:0] cacheAddr_t;
    typedef logic [`MC_TAG_W-1:0] tag_t;
    typedef logic [$clog2(`MC_LINE_WORDS)-1:0] beatIdx_t;

    typedef enum logic [1:0] {
        CMD_LOAD,
        CMD_STORE,
        CMD_FILL
    } memCmd_t;

    // Per-slot lifecycle
    typedef enum logic [1:0] {
        SLOT_FREE,
        SLOT_NEED_AR,
        SLOT_NEED_AW,
        SLOT_WAIT
    } slotState_t;

endpackage

`default_nettype wire

// File: hdl/slotLookupIf.sv
`timescale 1ns/1ns
`default_nettype none

interface slotLookupIf;

    // Beat at the head of the R buffer
    logic beatValid;
    memCtrlPkg::slotId_t beatId;
    logic beatAccept;

    // Slot information for that beat
    logic beatIsLoad;
    memCtrlPkg::cacheAddr_t beatCacheAddr;
    memCtrlPkg::tag_t beatTag;

    modport router (
        output beatValid, beatId, beatAccept,
        input beatIsLoad, beatCacheAddr, beatTag
    );

    modport slotTable (
        input beatValid, beatId, beatAccept,
        output beatIsLoad, beatCacheAddr, beatTag
    );

endinterface

`default_nettype wire

// File: hdl/transferTable.sv
`timescale 1ns/1ns
`default_nettype none

`include "memCtrl_defs.svh"

module transferTable (
    input wire clk,
    input wire rst,

    input wire reqValid,
    output logic reqReady,
    input memCtrlPkg::memCmd_t reqCmd,
    input memCtrlPkg::addr_t reqAddr,
    input memCtrlPkg::word_t reqData,
    input memCtrlPkg::cacheAddr_t reqCacheAddr,
    input memCtrlPkg::tag_t reqTag,

    output logic arValid,
    input wire arReady,
    output memCtrlPkg::slotId_t arId,
    output memCtrlPkg::addr_t arAddr,
    output logic [7:0] arLen,

    output logic awValid,
    input wire awReady,
    output memCtrlPkg::slotId_t awId,
    output memCtrlPkg::addr_t awAddr,
    output memCtrlPkg::word_t awData,
    output memCtrlPkg::tag_t awTag,

    input wire storeDoneValid,
    input memCtrlPkg::slotId_t storeDoneId,

    slotLookupIf.slotTable lookup
);

    localparam int LINE_SHIFT = $clog2(`MC_LINE_WORDS);
    localparam int LINE_BYTES = `MC_LINE_WORDS * `MC_DATA_W / 8;
    localparam int WORD_BYTES = `MC_DATA_W / 8;

    memCtrlPkg::slotState_t state [`MC_NUM_SLOTS];
    memCtrlPkg::memCmd_t cmd [`MC_NUM_SLOTS];
    memCtrlPkg::addr_t addr [`MC_NUM_SLOTS];
    memCtrlPkg::cacheAddr_t cacheBase [`MC_NUM_SLOTS];
    memCtrlPkg::tag_t tag [`MC_NUM_SLOTS];
    memCtrlPkg::word_t data [`MC_NUM_SLOTS];
    memCtrlPkg::beatIdx_t beatCnt [`MC_NUM_SLOTS];

    memCtrlPkg::slotId_t freeIdx;
    logic freeFound;
    logic lineCollide;
    logic reqFire;

    memCtrlPkg::slotId_t arPickIdx;
    logic arPickFound;
    logic arHold;
    memCtrlPkg::slotId_t arHoldId;

    memCtrlPkg::slotId_t awPickIdx;
    logic awPickFound;
    logic awHold;
    memCtrlPkg::slotId_t awHoldId;

    logic beatDone;

    // Lowest free slot, lowest slots waiting for AR and AW
    always_comb begin
        freeIdx = '0;
        freeFound = 1'b0;
        arPickIdx = '0;
        arPickFound = 1'b0;
        awPickIdx = '0;
        awPickFound = 1'b0;
        lineCollide = 1'b0;
        for (int i = 0; i < `MC_NUM_SLOTS; i++) begin
            if (!freeFound && state[i] == memCtrlPkg::SLOT_FREE) begin
                freeIdx = memCtrlPkg::slotId_t'(i);
                freeFound = 1'b1;
            end
            if (!arPickFound && state[i] == memCtrlPkg::SLOT_NEED_AR) begin
                arPickIdx = memCtrlPkg::slotId_t'(i);
                arPickFound = 1'b1;
            end
            if (!awPickFound && state[i] == memCtrlPkg::SLOT_NEED_AW) begin
                awPickIdx = memCtrlPkg::slotId_t'(i);
                awPickFound = 1'b1;
            end
            if (state[i] != memCtrlPkg::SLOT_FREE && cmd[i] == memCtrlPkg::CMD_FILL &&
                cacheBase[i][`MC_CACHE_ADDR_W-1:LINE_SHIFT] ==
                reqCacheAddr[`MC_CACHE_ADDR_W-1:LINE_SHIFT]) begin
                lineCollide = 1'b1;
            end
        end
    end

    assign reqReady = freeFound && !(reqCmd == memCtrlPkg::CMD_FILL && lineCollide);
    assign reqFire = reqValid && reqReady;

    // A channel stays locked to its slot until the handshake
    assign arValid = arHold || arPickFound;
    assign arId = arHold ? arHoldId : arPickIdx;
    assign arAddr = addr[arId];
    assign arLen = (cmd[arId] == memCtrlPkg::CMD_FILL) ? 8'(`MC_LINE_WORDS - 1) : 8'd0;

    assign awValid = awHold || awPickFound;
    assign awId = awHold ? awHoldId : awPickIdx;
    assign awAddr = addr[awId];
    assign awData = data[awId];
    assign awTag = tag[awId];

    // Answers for the beat at the R buffer head
    assign lookup.beatIsLoad = cmd[lookup.beatId] == memCtrlPkg::CMD_LOAD;
    assign lookup.beatCacheAddr = cacheBase[lookup.beatId] |
        memCtrlPkg::cacheAddr_t'(beatCnt[lookup.beatId]);
    assign lookup.beatTag = tag[lookup.beatId];
    assign beatDone = lookup.beatIsLoad ||
        beatCnt[lookup.beatId] == memCtrlPkg::beatIdx_t'(`MC_LINE_WORDS - 1);

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < `MC_NUM_SLOTS; i++) begin
                state[i] <= memCtrlPkg::SLOT_FREE;
            end
            arHold <= 1'b0;
            arHoldId <= '0;
            awHold <= 1'b0;
            awHoldId <= '0;
        end else begin
            arHold <= arValid && !arReady;
            arHoldId <= arId;
            awHold <= awValid && !awReady;
            awHoldId <= awId;

            if (reqFire) begin
                state[freeIdx] <= (reqCmd == memCtrlPkg::CMD_STORE) ?
                    memCtrlPkg::SLOT_NEED_AW : memCtrlPkg::SLOT_NEED_AR;
            end
            if (arValid && arReady) begin
                state[arId] <= memCtrlPkg::SLOT_WAIT;
            end
            if (awValid && awReady) begin
                state[awId] <= memCtrlPkg::SLOT_WAIT;
            end

            // Retirement
            if (lookup.beatAccept && beatDone) begin
                state[lookup.beatId] <= memCtrlPkg::SLOT_FREE;
            end
            if (storeDoneValid) begin
                state[storeDoneId] <= memCtrlPkg::SLOT_FREE;
            end
        end
    end

    // Slot payload
    always_ff @(posedge clk) begin
        if (reqFire) begin
            cmd[freeIdx] <= reqCmd;
            tag[freeIdx] <= reqTag;
            data[freeIdx] <= reqData;
            beatCnt[freeIdx] <= '0;
            if (reqCmd == memCtrlPkg::CMD_FILL) begin
                addr[freeIdx] <= reqAddr & ~memCtrlPkg::addr_t'(LINE_BYTES - 1);
                cacheBase[freeIdx] <=
                    reqCacheAddr & ~memCtrlPkg::cacheAddr_t'(`MC_LINE_WORDS - 1);
            end else begin
                addr[freeIdx] <= reqAddr & ~memCtrlPkg::addr_t'(WORD_BYTES - 1);
                cacheBase[freeIdx] <= reqCacheAddr;
            end
        end
        if (lookup.beatAccept) begin
            beatCnt[lookup.beatId] <= beatCnt[lookup.beatId] + 1'b1;
        end
    end

    // Returning data only for slots that issued AR
    assert property (@(posedge clk) disable iff (rst)
        lookup.beatValid |-> state[lookup.beatId] != memCtrlPkg::SLOT_FREE);

    assert property (@(posedge clk) disable iff (rst)
        storeDoneValid |-> state[storeDoneId] == memCtrlPkg::SLOT_WAIT);

endmodule

`default_nettype wire

// File: hdl/readDataRouter.sv
`timescale 1ns/1ns
`default_nettype none

`include "memCtrl_defs.svh"

module readDataRouter (
    input wire clk,
    input wire rst,

    input wire rValid,
    output logic rReady,
    input memCtrlPkg::slotId_t rId,
    input memCtrlPkg::word_t rData,
    input wire rLast,

    output logic cacheWe,
    output memCtrlPkg::cacheAddr_t cacheAddr,
    output memCtrlPkg::word_t cacheData,

    output logic ldValid,
    output memCtrlPkg::tag_t ldTag,
    output memCtrlPkg::word_t ldData,

    slotLookupIf.router lookup
);

    localparam int PTR_W = $clog2(`MC_RBUF_DEPTH);
    localparam int CNT_W = $clog2(`MC_RBUF_DEPTH + 1);

    memCtrlPkg::slotId_t bufId [`MC_RBUF_DEPTH];
    memCtrlPkg::word_t bufData [`MC_RBUF_DEPTH];
    logic bufLast [`MC_RBUF_DEPTH];

    logic [PTR_W-1:0] wrPtr;
    logic [PTR_W-1:0] rdPtr;
    logic [CNT_W-1:0] count;
    logic push;
    logic pop;

    assign rReady = count != CNT_W'(`MC_RBUF_DEPTH);
    assign push = rValid && rReady;

    // Neither the cache port nor the load output can stall
    assign lookup.beatValid = count != '0;
    assign lookup.beatId = bufId[rdPtr];
    assign lookup.beatAccept = lookup.beatValid;
    assign pop = lookup.beatAccept;

    always_ff @(posedge clk) begin
        if (rst) begin
            wrPtr <= '0;
            rdPtr <= '0;
            count <= '0;
            cacheWe <= 1'b0;
            ldValid <= 1'b0;
        end else begin
            if (push) begin
                wrPtr <= (wrPtr == PTR_W'(`MC_RBUF_DEPTH - 1)) ? '0 : wrPtr + 1'b1;
            end
            if (pop) begin
                rdPtr <= (rdPtr == PTR_W'(`MC_RBUF_DEPTH - 1)) ? '0 : rdPtr + 1'b1;
            end
            count <= count + CNT_W'(push) - CNT_W'(pop);
            cacheWe <= pop && !lookup.beatIsLoad;
            ldValid <= pop && lookup.beatIsLoad;
        end
    end

    always_ff @(posedge clk) begin
        if (push) begin
            bufId[wrPtr] <= rId;
            bufData[wrPtr] <= rData;
            bufLast[wrPtr] <= rLast;
        end
        cacheAddr <= lookup.beatCacheAddr;
        cacheData <= bufData[rdPtr];
        ldTag <= lookup.beatTag;
        ldData <= bufData[rdPtr];
    end

    // Burst length must agree with the slot's beat counter
    assert property (@(posedge clk) disable iff (rst)
        lookup.beatValid |-> bufLast[rdPtr] == (lookup.beatIsLoad ||
            lookup.beatCacheAddr[$clog2(`MC_LINE_WORDS)-1:0] ==
            memCtrlPkg::beatIdx_t'(`MC_LINE_WORDS - 1)));

endmodule

`default_nettype wire

// File: hdl/storeDataPath.sv
`timescale 1ns/1ns
`default_nettype none

`include "memCtrl_defs.svh"

module storeDataPath (
    input wire clk,
    input wire rst,

    input wire awFire,
    input memCtrlPkg::slotId_t awId,
    input memCtrlPkg::word_t awData,
    input memCtrlPkg::tag_t awTag,

    output logic wValid,
    input wire wReady,
    output memCtrlPkg::word_t wData,
    output logic [`MC_DATA_W/8-1:0] wStrb,
    output logic wLast,

    input wire bValid,
    output logic bReady,
    input memCtrlPkg::slotId_t bId,

    output logic stValid,
    output memCtrlPkg::tag_t stTag,
    output logic storeDoneValid,
    output memCtrlPkg::slotId_t storeDoneId
);

    localparam int CNT_W = $clog2(`MC_NUM_SLOTS + 1);

    // One queue entry per slot, so the queue never overflows
    memCtrlPkg::word_t wQueue [`MC_NUM_SLOTS];
    logic [`MC_ID_W-1:0] wrPtr;
    logic [`MC_ID_W-1:0] rdPtr;
    logic [CNT_W-1:0] count;
    logic wFire;
    logic bFire;

    memCtrlPkg::tag_t tagById [`MC_NUM_SLOTS];
    logic [`MC_NUM_SLOTS-1:0] outstanding;

    assign wValid = count != '0;
    assign wData = wQueue[rdPtr];
    assign wStrb = '1;
    // Single-beat bursts only
    assign wLast = 1'b1;
    assign wFire = wValid && wReady;
    assign bFire = bValid && bReady;

    assign storeDoneValid = stValid;

    always_ff @(posedge clk) begin
        if (rst) begin
            wrPtr <= '0;
            rdPtr <= '0;
            count <= '0;
            outstanding <= '0;
            bReady <= 1'b0;
            stValid <= 1'b0;
        end else begin
            bReady <= 1'b1;
            if (awFire) begin
                wrPtr <= wrPtr + 1'b1;
            end
            if (wFire) begin
                rdPtr <= rdPtr + 1'b1;
            end
            count <= count + CNT_W'(awFire) - CNT_W'(wFire);

            if (bFire) begin
                outstanding[bId] <= 1'b0;
            end
            if (awFire) begin
                outstanding[awId] <= 1'b1;
            end
            stValid <= bFire;
        end
    end

    always_ff @(posedge clk) begin
        if (awFire) begin
            wQueue[wrPtr] <= awData;
            tagById[awId] <= awTag;
        end
        stTag <= tagById[bId];
        storeDoneId <= bId;
    end

    assert property (@(posedge clk) disable iff (rst)
        bValid |-> outstanding[bId]);

endmodule

`default_nettype wire

// File: hdl/memCtrl.sv
`timescale 1ns/1ns
`default_nettype none

`include "memCtrl_defs.svh"

module memCtrl (
    input wire clk,
    input wire rst,

    // Client request
    input wire reqValid,
    output logic reqReady,
    input memCtrlPkg::memCmd_t reqCmd,
    input memCtrlPkg::addr_t reqAddr,
    input memCtrlPkg::word_t reqData,
    input memCtrlPkg::cacheAddr_t reqCacheAddr,
    input memCtrlPkg::tag_t reqTag,

    output logic ldValid,
    output memCtrlPkg::tag_t ldTag,
    output memCtrlPkg::word_t ldData,

    output logic stValid,
    output memCtrlPkg::tag_t stTag,

    // Data cache write port
    output logic cacheWe,
    output memCtrlPkg::cacheAddr_t cacheAddr,
    output memCtrlPkg::word_t cacheData,

    // AXI4 read
    output logic arValid,
    input wire arReady,
    output memCtrlPkg::slotId_t arId,
    output memCtrlPkg::addr_t arAddr,
    output logic [7:0] arLen,
    output logic [2:0] arSize,
    output logic [1:0] arBurst,

    input wire rValid,
    output logic rReady,
    input memCtrlPkg::slotId_t rId,
    input memCtrlPkg::word_t rData,
    input wire rLast,

    // AXI4 write
    output logic awValid,
    input wire awReady,
    output memCtrlPkg::slotId_t awId,
    output memCtrlPkg::addr_t awAddr,
    output logic [7:0] awLen,
    output logic [2:0] awSize,
    output logic [1:0] awBurst,

    output logic wValid,
    input wire wReady,
    output memCtrlPkg::word_t wData,
    output logic [`MC_DATA_W/8-1:0] wStrb,
    output logic wLast,

    input wire bValid,
    output logic bReady,
    input memCtrlPkg::slotId_t bId
);

    memCtrlPkg::word_t awData;
    memCtrlPkg::tag_t awTag;
    logic storeDoneValid;
    memCtrlPkg::slotId_t storeDoneId;

    slotLookupIf lookup ();

    // Full-width INCR bursts, stores are always one beat
    assign arSize = 3'($clog2(`MC_DATA_W / 8));
    assign arBurst = 2'b01;
    assign awSize = 3'($clog2(`MC_DATA_W / 8));
    assign awBurst = 2'b01;
    assign awLen = 8'd0;

    transferTable transferTableInst (
        .clk(clk), .rst(rst),
        .reqValid(reqValid), .reqReady(reqReady), .reqCmd(reqCmd), .reqAddr(reqAddr),
        .reqData(reqData), .reqCacheAddr(reqCacheAddr), .reqTag(reqTag),
        .arValid(arValid), .arReady(arReady), .arId(arId), .arAddr(arAddr), .arLen(arLen),
        .awValid(awValid), .awReady(awReady), .awId(awId), .awAddr(awAddr),
        .awData(awData), .awTag(awTag),
        .storeDoneValid(storeDoneValid), .storeDoneId(storeDoneId),
        .lookup(lookup.slotTable)
    );

    readDataRouter readDataRouterInst (
        .clk(clk), .rst(rst),
        .rValid(rValid), .rReady(rReady), .rId(rId), .rData(rData), .rLast(rLast),
        .cacheWe(cacheWe), .cacheAddr(cacheAddr), .cacheData(cacheData),
        .ldValid(ldValid), .ldTag(ldTag), .ldData(ldData),
        .lookup(lookup.router)
    );

    storeDataPath storeDataPathInst (
        .clk(clk), .rst(rst),
        .awFire(awValid && awReady), .awId(awId), .awData(awData), .awTag(awTag),
        .wValid(wValid), .wReady(wReady), .wData(wData), .wStrb(wStrb), .wLast(wLast),
        .bValid(bValid), .bReady(bReady), .bId(bId),
        .stValid(stValid), .stTag(stTag),
        .storeDoneValid(storeDoneValid), .storeDoneId(storeDoneId)
    );

endmodule

`default_nettype wire

// File: dv/tb_memCtrl.sv
`timescale 1ns/1ns
`default_nettype none

`include "memCtrl_defs.svh"

module tb_memCtrl;

    localparam int REQ_TIMEOUT = 1000;
    localparam int IDLE_TIMEOUT = 4000;
    localparam int RANDOM_REQS = 48;

    logic clk;
    logic rst;
    logic reqValid;
    logic reqReady;
    memCtrlPkg::memCmd_t reqCmd;
    memCtrlPkg::addr_t reqAddr;
    memCtrlPkg::word_t reqData;
    memCtrlPkg::cacheAddr_t reqCacheAddr;
    memCtrlPkg::tag_t reqTag;
    logic ldValid;
    memCtrlPkg::tag_t ldTag;
    memCtrlPkg::word_t ldData;
    logic stValid;
    memCtrlPkg::tag_t stTag;
    logic cacheWe;
    memCtrlPkg::cacheAddr_t cacheAddr;
    memCtrlPkg::word_t cacheData;
    logic arValid, arReady;
    memCtrlPkg::slotId_t arId;
    memCtrlPkg::addr_t arAddr;
    logic [7:0] arLen;
    logic [2:0] arSize;
    logic [1:0] arBurst;
    logic rValid, rReady, rLast;
    memCtrlPkg::slotId_t rId;
    memCtrlPkg::word_t rData;
    logic awValid, awReady;
    memCtrlPkg::slotId_t awId;
    memCtrlPkg::addr_t awAddr;
    logic [7:0] awLen;
    logic [2:0] awSize;
    logic [1:0] awBurst;
    logic wValid, wReady, wLast;
    memCtrlPkg::word_t wData;
    logic [`MC_DATA_W/8-1:0] wStrb;
    logic bValid, bReady;
    memCtrlPkg::slotId_t bId;

    // Memory model state
    memCtrlPkg::word_t mem [logic [29:0]];
    logic [`MC_NUM_SLOTS-1:0] rdPend;
    memCtrlPkg::addr_t rdAddr [`MC_NUM_SLOTS];
    logic [7:0] rdLen [`MC_NUM_SLOTS];
    int rdBeat [`MC_NUM_SLOTS];
    logic rFired;
    memCtrlPkg::addr_t awAddrQ [$];
    memCtrlPkg::slotId_t awIdQ [$];
    logic [`MC_NUM_SLOTS-1:0] bPend;
    logic bFired;
    logic holdBus;
    logic [31:0] seed = 32'hbc38943b;

    // Scoreboard
    memCtrlPkg::word_t shadow [logic [29:0]];
    memCtrlPkg::word_t expStoreData [logic [29:0]];
    logic [255:0] ldPend;
    memCtrlPkg::word_t ldExp [256];
    logic [255:0] stPend;
    logic [(1<<`MC_CACHE_ADDR_W)-1:0] cachePend;
    memCtrlPkg::word_t cacheExp [1<<`MC_CACHE_ADDR_W];
    int outstandingCount;

    memCtrl memCtrl_inst (.*);

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    function automatic logic [31:0] lcgNext();
        seed = seed * 32'd1664525 + 32'd1013904223;
        return seed;
    endfunction

    // Odd multiplier gives every word address its own pattern
    function automatic memCtrlPkg::word_t initWord(memCtrlPkg::addr_t a);
        return ((a >> 2) * 32'h9e3779b1) ^ 32'h5ac30f69;
    endfunction

    function automatic memCtrlPkg::word_t memRead(memCtrlPkg::addr_t a);
        return mem.exists(a[31:2]) ? mem[a[31:2]] : initWord(a);
    endfunction

    function automatic memCtrlPkg::word_t shadowRead(memCtrlPkg::addr_t a);
        return shadow.exists(a[31:2]) ? shadow[a[31:2]] : initWord(a);
    endfunction

    function automatic int pickPending(logic [`MC_NUM_SLOTS-1:0] pend, logic [1:0] start);
        int idx;
        for (int k = 0; k < `MC_NUM_SLOTS; k++) begin
            idx = (int'(start) + k) % `MC_NUM_SLOTS;
            if (pend[idx]) begin
                return idx;
            end
        end
        return -1;
    endfunction

    task automatic failRun(string msg);
        $display("%s", msg);
        $display("TB FAILED");
        $fatal(1, "Stopped at the first error");
    endtask

    task automatic checkValue(string name, logic [31:0] got, logic [31:0] exp);
        assert (got === exp)
            else failRun($sformatf("Fail %s: got 0x%h, expected 0x%h", name, got, exp));
    endtask

    // Drives and holds the model outputs between clock edges
    always @(negedge clk) begin
        logic [31:0] r;
        int pick;
        r = lcgNext();
        if (rst) begin
            arReady = 1'b0;
            awReady = 1'b0;
            wReady = 1'b0;
            rValid = 1'b0;
            bValid = 1'b0;
            rFired = 1'b0;
            bFired = 1'b0;
        end else begin
            arReady = !holdBus && r[17];
            awReady = !holdBus && r[19];
            wReady = r[21] | r[22];
            if (!rValid || rFired) begin
                rFired = 1'b0;
                rValid = 1'b0;
                pick = (r[24] | r[25]) ? pickPending(rdPend, r[27:26]) : -1;
                if (pick >= 0) begin
                    rValid = 1'b1;
                    rId = memCtrlPkg::slotId_t'(pick);
                    rData = memRead(rdAddr[pick] + 32'(rdBeat[pick] * 4));
                    rLast = rdBeat[pick] == int'(rdLen[pick]);
                end
            end
            if (!bValid || bFired) begin
                bFired = 1'b0;
                bValid = 1'b0;
                pick = (r[28] | r[29]) ? pickPending(bPend, r[31:30]) : -1;
                if (pick >= 0) begin
                    bValid = 1'b1;
                    bId = memCtrlPkg::slotId_t'(pick);
                end
            end
        end
    end

    // Handshakes and results as they stood just before the edge
    always @(posedge clk) begin
        memCtrlPkg::addr_t wAddr;
        memCtrlPkg::slotId_t wId;
        if (!rst) begin
            if (arValid && arReady) begin
                assert (!rdPend[arId]) else failRun("AR issued on an ID that is still busy");
                rdPend[arId] = 1'b1;
                rdAddr[arId] = arAddr;
                rdLen[arId] = arLen;
                rdBeat[arId] = 0;
            end
            if (rValid && rReady) begin
                rFired = 1'b1;
                rdBeat[rId] = rdBeat[rId] + 1;
                if (rLast) begin
                    rdPend[rId] = 1'b0;
                end
            end
            if (awValid && awReady) begin
                awAddrQ.push_back(awAddr);
                awIdQ.push_back(awId);
            end
            if (wValid && wReady) begin
                assert (awAddrQ.size() != 0) else failRun("W beat arrived before its AW");
                wAddr = awAddrQ.pop_front();
                wId = awIdQ.pop_front();
                checkValue("wStrb", 32'(wStrb), 32'hf);
                checkValue("wLast", 32'(wLast), 32'h1);
                assert (expStoreData.exists(wAddr[31:2]))
                    else failRun("W beat for an address that no store targets");
                checkValue("wData", wData, expStoreData[wAddr[31:2]]);
                mem[wAddr[31:2]] = wData;
                bPend[wId] = 1'b1;
            end
            if (bValid && bReady) begin
                bPend[bId] = 1'b0;
                bFired = 1'b1;
            end
            if (ldValid) begin
                assert (ldPend[ldTag])
                    else failRun("Load result for a tag with no load pending");
                checkValue("ldData", ldData, ldExp[ldTag]);
                ldPend[ldTag] = 1'b0;
                outstandingCount--;
            end
            if (stValid) begin
                assert (stPend[stTag])
                    else failRun("Store result for a tag with no store pending");
                stPend[stTag] = 1'b0;
                outstandingCount--;
            end
            if (cacheWe) begin
                assert (cachePend[cacheAddr])
                    else failRun("Cache write to an address not being filled");
                checkValue("cacheData", cacheData, cacheExp[cacheAddr]);
                cachePend[cacheAddr] = 1'b0;
                outstandingCount--;
            end
        end
    end

    // AXI rules on the DUT side
    assert property (@(posedge clk) disable iff (rst) arValid && !arReady |=>
        arValid && $stable(arId) && $stable(arAddr) && $stable(arLen))
        else failRun("AR request dropped or changed before its handshake");
    assert property (@(posedge clk) disable iff (rst) awValid && !awReady |=>
        awValid && $stable(awId) && $stable(awAddr))
        else failRun("AW request dropped or changed before its handshake");
    assert property (@(posedge clk) disable iff (rst) wValid && !wReady |=>
        wValid && $stable(wData))
        else failRun("W beat dropped or changed before its handshake");
    assert property (@(posedge clk) disable iff (rst) arValid |->
        arBurst == 2'b01 && arSize == 3'd2 && (arLen == 8'd0 ||
        (arLen == 8'd3 && arAddr[3:0] == 4'h0)))
        else failRun("AR carries an unexpected burst shape");
    assert property (@(posedge clk) disable iff (rst) awValid |->
        awBurst == 2'b01 && awSize == 3'd2 && awLen == 8'd0)
        else failRun("AW carries an unexpected burst shape");

    task automatic issue(memCtrlPkg::memCmd_t cmd, memCtrlPkg::addr_t addr,
                         memCtrlPkg::word_t data, memCtrlPkg::cacheAddr_t cAddr,
                         memCtrlPkg::tag_t tag);
        int waitCycles;
        logic accepted;
        memCtrlPkg::addr_t lineAddr;
        memCtrlPkg::cacheAddr_t lineBase;
        lineAddr = addr & ~32'hf;
        lineBase = cAddr & ~10'h3;
        if (cmd == memCtrlPkg::CMD_LOAD) begin
            assert (!ldPend[tag]) else failRun("Load tag reused while still pending");
            ldPend[tag] = 1'b1;
            ldExp[tag] = shadowRead(addr);
            outstandingCount++;
        end else if (cmd == memCtrlPkg::CMD_STORE) begin
            assert (!stPend[tag]) else failRun("Store tag reused while still pending");
            stPend[tag] = 1'b1;
            shadow[addr[31:2]] = data;
            expStoreData[addr[31:2]] = data;
            outstandingCount++;
        end else begin
            for (int k = 0; k < `MC_LINE_WORDS; k++) begin
                cachePend[lineBase + k] = 1'b1;
                cacheExp[lineBase + k] = shadowRead(lineAddr + 32'(4 * k));
            end
            outstandingCount += `MC_LINE_WORDS;
        end
        reqValid = 1'b1;
        reqCmd = cmd;
        reqAddr = addr;
        reqData = data;
        reqCacheAddr = cAddr;
        reqTag = tag;
        waitCycles = 0;
        accepted = 1'b0;
        while (!accepted) begin
            @(posedge clk);
            if (reqReady) begin
                accepted = 1'b1;
            end else if (++waitCycles > REQ_TIMEOUT) begin
                failRun("Timeout waiting for reqReady");
            end
        end
        @(negedge clk);
        reqValid = 1'b0;
    endtask

    task automatic waitIdle();
        int waitCycles;
        waitCycles = 0;
        do begin
            @(negedge clk);
            if (++waitCycles > IDLE_TIMEOUT) begin
                failRun("Timeout waiting for outstanding requests to complete");
            end
        end while (outstandingCount != 0);
    endtask

    initial begin
        logic [31:0] r;
        memCtrlPkg::addr_t base;
        rst = 1'b1;
        reqValid = 1'b0;
        reqCmd = memCtrlPkg::CMD_LOAD;
        reqAddr = '0;
        reqData = '0;
        reqCacheAddr = '0;
        reqTag = '0;
        arReady = 1'b0;
        awReady = 1'b0;
        wReady = 1'b0;
        rValid = 1'b0;
        rId = '0;
        rData = '0;
        rLast = 1'b0;
        bValid = 1'b0;
        bId = '0;
        rdPend = '0;
        bPend = '0;
        rFired = 1'b0;
        bFired = 1'b0;
        holdBus = 1'b0;
        ldPend = '0;
        stPend = '0;
        cachePend = '0;
        outstandingCount = 0;
        repeat (3) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;

        // Idle state after reset
        repeat (4) begin
            @(posedge clk);
            assert (reqReady && !arValid && !awValid && !wValid && !ldValid && !stValid &&
                !cacheWe) else failRun("Outputs not in their idle state after reset");
        end
        @(negedge clk);

        issue(memCtrlPkg::CMD_LOAD, 32'h0000_0124, '0, '0, 8'd1);
        waitIdle();
        issue(memCtrlPkg::CMD_STORE, 32'h0000_0200, 32'hcafe_f00d, '0, 8'd2);
        waitIdle();
        issue(memCtrlPkg::CMD_LOAD, 32'h0000_0200, '0, '0, 8'd3);
        waitIdle();

        // A fill followed by a second fill to the same cache line
        issue(memCtrlPkg::CMD_FILL, 32'h0000_1000, '0, 10'h040, 8'd4);
        reqCmd = memCtrlPkg::CMD_FILL;
        reqAddr = 32'h0000_2000;
        reqCacheAddr = 10'h042;
        @(posedge clk);
        assert (!reqReady) else failRun("Colliding fill was not refused");
        waitIdle();

        // Four loads stuck on AR fill the table
        holdBus = 1'b1;
        @(negedge clk);
        for (int i = 0; i < `MC_NUM_SLOTS; i++) begin
            issue(memCtrlPkg::CMD_LOAD, 32'h0000_3000 + 32'(i * 4), '0, '0, 8'(10 + i));
        end
        reqCmd = memCtrlPkg::CMD_LOAD;
        @(posedge clk);
        assert (!reqReady) else failRun("reqReady high with every slot in use");
        @(negedge clk);
        holdBus = 1'b0;
        waitIdle();

        // Random mix with each request in its own address region
        for (int i = 0; i < RANDOM_REQS; i++) begin
            r = lcgNext();
            base = 32'h0002_0000 + 32'(i * 64);
            if (r[25:24] == 2'd0) begin
                issue(memCtrlPkg::CMD_STORE, base + 32'(4 * r[19:18]), lcgNext(), '0,
                    8'(64 + i));
            end else if (r[25:24] == 2'd1) begin
                issue(memCtrlPkg::CMD_FILL, base, '0,
                    10'(512 + i * 4) | 10'(r[21:20]), 8'(64 + i));
            end else begin
                issue(memCtrlPkg::CMD_LOAD, base + 32'(4 * r[19:18]), '0, '0, 8'(64 + i));
            end
        end
        waitIdle();

        $display("TB PASSED");
        $finish;
    end

endmodule

`default_nettype wire

// File: sim.f
+incdir+include
hdl/memCtrlPkg.sv
hdl/slotLookupIf.sv
hdl/transferTable.sv
hdl/readDataRouter.sv
hdl/storeDataPath.sv
hdl/memCtrl.sv
dv/tb_memCtrl.sv

// File: run.sh
#!/usr/bin/env bash
set -u
cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --assert -Wno-fatal \
    --top-module tb_memCtrl --Mdir obj_dir -o tb_memCtrl -f sim.f
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

./obj_dir/tb_memCtrl > "$LOG" 2>&1
simStatus=$?
cat "$LOG"
if [ $simStatus -ne 0 ]; then
    echo "Simulation exited with status $simStatus"
    exit 1
fi

if grep -q "^TB PASSED$" "$LOG"; then
    exit 0
fi
echo "Pass message not found in $LOG"
exit 1
